//--- flist.f
+incdir+include
hw/bpu_pkg.sv
hw/counter_table.sv
hw/update_stage.sv
hw/accuracy_counter.sv
hw/branch_predictor.sv
testbench/tb_branch_predictor.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_branch_predictor
FLIST     := flist.f

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FLIST))
HEADERS   := $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- include/bp_model.svh
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

// Reference model of the predictor table and its statistics.
localparam int MODEL_ENTRIES = 1 << INDEX_BITS;

bit                   ref_valid [MODEL_ENTRIES];
bit [63-INDEX_BITS:0] ref_tag   [MODEL_ENTRIES];
bit [1:0]             ref_ctr   [MODEL_ENTRIES];
bpu_pkg::ip_t         pend_ip;
bit                   pend_hit; // Entry state as read at lookup time.
bit [1:0]             pend_ctr;
bpu_pkg::stat_t       exp_branch_count;
bpu_pkg::stat_t       exp_mispredict_count;

function automatic void clear_model();
	foreach (ref_valid[i]) begin
		ref_valid[i] = 1'b0;
	end
	exp_branch_count     = '0;
	exp_mispredict_count = '0;
endfunction

function automatic bit entry_hits(bpu_pkg::ip_t ip);
	bit [INDEX_BITS-1:0] idx;
	idx = ip[INDEX_BITS-1:0];
	return ref_valid[idx] && (ref_tag[idx] == ip[63:INDEX_BITS]);
endfunction

// Prediction for ip from the table as it stands now.
function automatic bit predict_taken(bpu_pkg::ip_t ip);
	return entry_hits(ip) && ref_ctr[ip[INDEX_BITS-1:0]][1];
endfunction

// One clock edge. The lookup reads before the resolve writes; returns mispredict.
function automatic bit advance_model(bit lk_valid, bpu_pkg::ip_t ip, bit rs_valid, bit taken);
	bit                  new_hit;
	bit [1:0]            new_ctr;
	bit [INDEX_BITS-1:0] idx;
	bit                  mispredicted;
	new_hit      = entry_hits(ip);
	new_ctr      = ref_ctr[ip[INDEX_BITS-1:0]];
	idx          = pend_ip[INDEX_BITS-1:0];
	mispredicted = 1'b0;
	if (rs_valid) begin
		mispredicted = ((pend_hit && pend_ctr[1]) != taken);
		if (!pend_hit) begin
			ref_ctr[idx] = taken ? 2'b10 : 2'b01;
		end else if (taken && pend_ctr != 2'b11) begin
			ref_ctr[idx] = pend_ctr + 2'b01;
		end else if (!taken && pend_ctr != 2'b00) begin
			ref_ctr[idx] = pend_ctr - 2'b01;
		end else begin
			ref_ctr[idx] = pend_ctr;
		end
		ref_valid[idx] = 1'b1;
		ref_tag[idx]   = pend_ip[63:INDEX_BITS];
		exp_branch_count++;
		if (mispredicted) begin
			exp_mispredict_count++;
		end
	end
	if (lk_valid) begin
		pend_ip  = ip;
		pend_hit = new_hit;
		pend_ctr = new_ctr;
	end
	return mispredicted;
endfunction

`endif

//--- testbench/tb_branch_predictor.sv
`timescale 1ns/1ns

module tb_branch_predictor;
	import bpu_pkg::*;

	localparam int INDEX_BITS    = 8;
	localparam int RANDOM_CYCLES = 3000;
	localparam int RESET_TIMEOUT = 20;
	localparam logic [55:0] TAG_BASE = 56'h12_3456_789a_bc00; // Low two bits pick the bias.

	logic  clk;
	logic  rst_n;
	logic  lookup_valid;
	ip_t   lookup_ip;
	logic  resolve_valid;
	logic  resolve_taken;
	logic  prediction;
	logic  mispredict;
	stat_t branch_count;
	stat_t mispredict_count;

	logic last_lookup; // A lookup was driven in the previous cycle.
	ip_t  last_ip;
	logic seen_pred;   // DUT prediction sampled in the latest cycle.

`include "bp_model.svh"

	branch_predictor #(
		.INDEX_BITS (INDEX_BITS)
	) branch_predictor_inst (
		.clk              (clk),
		.rst_n            (rst_n),
		.lookup_valid     (lookup_valid),
		.lookup_ip        (lookup_ip),
		.resolve_valid    (resolve_valid),
		.resolve_taken    (resolve_taken),
		.prediction       (prediction),
		.mispredict       (mispredict),
		.branch_count     (branch_count),
		.mispredict_count (mispredict_count)
	);

	always #2 clk = ~clk;

	// Four tags over four indices, so that the same index is shared by several tags.
	function automatic ip_t make_ip(input logic [1:0] t, input logic [1:0] i);
		logic [7:0] index;
		case (i)
			2'd0:    index = 8'h00;
			2'd1:    index = 8'h05;
			2'd2:    index = 8'h80;
			default: index = 8'hff;
		endcase
		return {TAG_BASE + 56'(t), index};
	endfunction

	// Percent chance of taken, fixed per tag.
	function automatic int taken_bias(input ip_t ip);
		case (ip[9:8])
			2'd0:    return 5;
			2'd1:    return 95;
			2'd2:    return 65;
			default: return 30;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("TEST FAILED");
			$fatal(1, "stopping at first error");
		end
	endtask

	// Drives one cycle and checks it; the counts seen here belong to the previous edge.
	task automatic run_cycle(input bit lk, input ip_t ip, input bit rs, input bit taken);
		bit exp_mis;
		@(negedge clk);
		check_value("branch_count", 64'(branch_count), 64'(exp_branch_count));
		check_value("mispredict_count", 64'(mispredict_count), 64'(exp_mispredict_count));
		lookup_valid  = lk;
		lookup_ip     = ip;
		resolve_valid = rs;
		resolve_taken = taken;
		#1;
		seen_pred = prediction;
		if (lk) begin
			check_value("prediction", 64'(prediction), 64'(predict_taken(ip)));
		end
		exp_mis = advance_model(lk, ip, rs, taken); // Applies this edge's update.
		check_value("mispredict", 64'(mispredict), 64'(exp_mis));
		last_lookup = lk;
		if (lk) begin
			last_ip = ip;
		end
	endtask

	task automatic expect_lookup(input ip_t ip, input bit exp_pred);
		run_cycle(1'b1, ip, 1'b0, 1'b0);
		check_value("prediction", 64'(seen_pred), 64'(exp_pred));
	endtask

	task automatic lookup_resolve(input ip_t ip, input bit taken, input bit exp_pred);
		expect_lookup(ip, exp_pred);
		run_cycle(1'b0, ip, 1'b1, taken);
	endtask

	task automatic apply_reset();
		int waited;
		@(negedge clk);
		rst_n         = 1'b0;
		lookup_valid  = 1'b0;
		resolve_valid = 1'b0;
		resolve_taken = 1'b0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		clear_model();
		last_lookup = 1'b0;
		waited = 0;
		while (branch_count !== '0 || mispredict_count !== '0) begin
			if (waited == RESET_TIMEOUT) begin
				$display("Statistics did not clear within %0d cycles of reset", RESET_TIMEOUT);
				$display("TEST FAILED");
				$fatal(1, "reset timeout");
			end
			@(negedge clk);
			waited++;
		end
	endtask

	// Every pool address must miss and predict not-taken on a fresh table.
	task automatic check_cold_table();
		for (int t = 0; t < 4; t++) begin
			for (int i = 0; i < 4; i++) begin
				expect_lookup(make_ip(2'(t), 2'(i)), 1'b0);
			end
		end
		run_cycle(1'b0, '0, 1'b0, 1'b0);
		check_value("branch_count", 64'(branch_count), 64'd0);
		check_value("mispredict_count", 64'(mispredict_count), 64'd0);
	endtask

	task automatic directed_sequence();
		ip_t a;
		ip_t b;
		a = make_ip(2'd0, 2'd1);
		b = make_ip(2'd1, 2'd1); // Same index as a, other tag.
		lookup_resolve(a, 1'b1, 1'b0); // Allocates weak_t.
		lookup_resolve(a, 1'b1, 1'b1); // Now strong_t.
		lookup_resolve(a, 1'b0, 1'b1);
		lookup_resolve(a, 1'b0, 1'b1); // Hysteresis held for one not-taken.
		expect_lookup(a, 1'b0);
		run_cycle(1'b0, '0, 1'b0, 1'b0);
		// Tag conflict replaces the entry.
		lookup_resolve(b, 1'b1, 1'b0);
		expect_lookup(a, 1'b0);
		expect_lookup(b, 1'b1);
		// The lookup beside its own update sees the old counter.
		run_cycle(1'b1, b, 1'b1, 1'b0);
		check_value("prediction", 64'(seen_pred), 64'd1);
		expect_lookup(b, 1'b0);
		run_cycle(1'b0, '0, 1'b0, 1'b0);
	endtask

	task automatic random_traffic(input int cycles);
		bit  lk;
		bit  tk;
		ip_t ip;
		for (int n = 0; n < cycles; n++) begin
			lk = ($urandom % 4) != 0;
			ip = make_ip(2'($urandom), 2'($urandom));
			tk = ($urandom % 100) < taken_bias(last_ip);
			run_cycle(lk, ip, last_lookup, tk); // Every lookup gets its resolution.
		end
		run_cycle(1'b0, '0, last_lookup, 1'b0);
		run_cycle(1'b0, '0, 1'b0, 1'b0);
	endtask

	initial begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		lookup_valid  = 1'b0;
		lookup_ip     = '0;
		resolve_valid = 1'b0;
		resolve_taken = 1'b0;
		last_lookup   = 1'b0;
		last_ip       = '0;
		seen_pred     = 1'b0;
		void'($urandom(32'heefd_f8fe));
		apply_reset();
		check_cold_table();
		directed_sequence();
		random_traffic(RANDOM_CYCLES);
		apply_reset(); // Mid-run reset must wipe the trained table.
		check_cold_table();
		random_traffic(500);
		$display("TEST PASSED");
		$finish;
	end

	initial begin
		#100000;
		$display("Simulation ran past its time limit");
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

endmodule

//--- hw/branch_predictor.sv
`timescale 1ns/1ns

module branch_predictor #(
	parameter int INDEX_BITS = 8
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           lookup_valid,
	input  bpu_pkg::ip_t   lookup_ip,
	input  logic           resolve_valid,
	input  logic           resolve_taken,
	output logic           prediction,
	output logic           mispredict,
	output bpu_pkg::stat_t branch_count,
	output bpu_pkg::stat_t mispredict_count
);
	import bpu_pkg::*;

	lookup_s      lookup_rd;
	logic         table_wr_en;
	table_write_s table_wr;

	counter_table #(
		.INDEX_BITS (INDEX_BITS)
	) counter_table_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.lookup_ip   (lookup_ip),
		.table_wr_en (table_wr_en),
		.table_wr    (table_wr),
		.lookup_rd   (lookup_rd)
	);

	update_stage update_stage_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.lookup_valid  (lookup_valid),
		.lookup_rd     (lookup_rd),
		.resolve_valid (resolve_valid),
		.resolve_taken (resolve_taken),
		.table_wr_en   (table_wr_en),
		.table_wr      (table_wr),
		.mispredict    (mispredict)
	);

	accuracy_counter accuracy_counter_inst (
		.clk              (clk),
		.rst_n            (rst_n),
		.resolve_valid    (resolve_valid),
		.mispredict       (mispredict),
		.branch_count     (branch_count),
		.mispredict_count (mispredict_count)
	);

	// Taken only when the entry belongs to this address and leans taken.
	assign prediction = lookup_rd.hit && lookup_rd.ctr[1];

endmodule

//--- hw/accuracy_counter.sv
`timescale 1ns/1ns

module accuracy_counter (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           resolve_valid,
	input  logic           mispredict,
	output bpu_pkg::stat_t branch_count,
	output bpu_pkg::stat_t mispredict_count
);
	import bpu_pkg::*;

	stat_t branch_count_q;
	stat_t mispredict_count_q;

	// Both counts wrap silently at the top of their range.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			branch_count_q     <= '0;
			mispredict_count_q <= '0;
		end else if (resolve_valid) begin
			branch_count_q <= branch_count_q + stat_t'(1);
			if (mispredict) begin
				mispredict_count_q <= mispredict_count_q + stat_t'(1);
			end
		end
	end

	assign branch_count     = branch_count_q;
	assign mispredict_count = mispredict_count_q;

	// The update stage only flags a mispredict on a resolution.
	mispredict_on_resolve: assert property (
		@(posedge clk) disable iff (!rst_n) mispredict |-> resolve_valid
	) else $error("accuracy_counter: mispredict outside a resolve cycle");

endmodule

//--- hw/update_stage.sv
`timescale 1ns/1ns

module update_stage (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  lookup_valid,
	input  bpu_pkg::lookup_s      lookup_rd,
	input  logic                  resolve_valid,
	input  logic                  resolve_taken,
	output logic                  table_wr_en,
	output bpu_pkg::table_write_s table_wr,
	output logic                  mispredict
);
	import bpu_pkg::*;

	lookup_s pending_q;     // Read result of the most recent lookup.
	logic    lookup_last_q; // A lookup was made in the previous cycle.
	logic    resolve_fire;
	logic    predicted;
	ctr_t    next_ctr;

	always_ff @(posedge clk) begin
		if (lookup_valid) begin
			pending_q <= lookup_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lookup_last_q <= 1'b0;
		end else begin
			lookup_last_q <= lookup_valid;
		end
	end

	assign resolve_fire = resolve_valid && lookup_last_q;

	// Same rule as the top level: a miss predicts not-taken.
	assign predicted = pending_q.hit && pending_q.ctr[1];

	// Saturating step on a hit, weak allocation on a miss.
	always_comb begin
		if (!pending_q.hit) begin
			next_ctr = resolve_taken ? weak_t : weak_nt;
		end else begin
			case (pending_q.ctr)
				strong_nt: next_ctr = resolve_taken ? weak_nt  : strong_nt;
				weak_nt:   next_ctr = resolve_taken ? weak_t   : strong_nt;
				weak_t:    next_ctr = resolve_taken ? strong_t : weak_nt;
				strong_t:  next_ctr = resolve_taken ? strong_t : weak_t;
				default:   next_ctr = weak_nt;
			endcase
		end
	end

	always_comb begin
		table_wr.ip  = pending_q.ip;
		table_wr.ctr = next_ctr;
	end

	assign table_wr_en = resolve_fire;
	assign mispredict  = resolve_fire && (predicted != resolve_taken);

	// Resolutions must trail their lookup by exactly one cycle.
	resolve_after_lookup: assert property (
		@(posedge clk) disable iff (!rst_n) resolve_valid |-> lookup_last_q
	) else $error("update_stage: resolve without a lookup in the previous cycle");

endmodule

//--- hw/counter_table.sv
`timescale 1ns/1ns

module counter_table #(
	parameter int INDEX_BITS = 8
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  bpu_pkg::ip_t          lookup_ip,
	input  logic                  table_wr_en,
	input  bpu_pkg::table_write_s table_wr,
	output bpu_pkg::lookup_s      lookup_rd
);
	import bpu_pkg::*;

	localparam int ENTRIES  = 1 << INDEX_BITS;
	localparam int TAG_BITS = $bits(ip_t) - INDEX_BITS;

	typedef logic [INDEX_BITS-1:0] index_t;
	typedef logic [TAG_BITS-1:0]   tag_t;

	logic [ENTRIES-1:0] valid_q; // Only the valid bits are cleared on reset.
	tag_t               tag_mem [ENTRIES];
	ctr_t               ctr_mem [ENTRIES];

	index_t rd_index;
	tag_t   rd_tag;
	index_t wr_index;
	tag_t   wr_tag;

	// Low bits select the entry, the rest of the address is the tag.
	assign rd_index = lookup_ip[INDEX_BITS-1:0];
	assign rd_tag   = lookup_ip[$bits(ip_t)-1:INDEX_BITS];
	assign wr_index = table_wr.ip[INDEX_BITS-1:0];
	assign wr_tag   = table_wr.ip[$bits(ip_t)-1:INDEX_BITS];

	// The read port sees the table as it was before this edge's write.
	always_comb begin
		lookup_rd.ip  = lookup_ip;
		lookup_rd.hit = valid_q[rd_index] && (tag_mem[rd_index] == rd_tag);
		lookup_rd.ctr = ctr_mem[rd_index]; // Meaningless on a miss.
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (table_wr_en) begin
			valid_q[wr_index] <= 1'b1;
		end
	end

	// A write always (re)allocates, so tag and counter go in together.
	always_ff @(posedge clk) begin
		if (table_wr_en) begin
			tag_mem[wr_index] <= wr_tag;
			ctr_mem[wr_index] <= table_wr.ctr;
		end
	end

	// The update stage must have dropped its write enable whenever reset is held.
	write_outside_reset: assert property (@(posedge clk) !rst_n |-> !table_wr_en)
		else $error("counter_table: write while in reset");

endmodule

//--- hw/bpu_pkg.sv
package bpu_pkg;

	// Full fetch address as presented by the front end.
	typedef logic [63:0] ip_t;

	// Two-bit saturating counter; the upper bit is the prediction.
	typedef enum logic [1:0] {
		strong_nt = 2'b00,
		weak_nt   = 2'b01,
		weak_t    = 2'b10,
		strong_t  = 2'b11
	} ctr_t;

	// Resolved-branch and mispredict statistics.
	typedef logic [31:0] stat_t;

	// Table read result, kept by the update stage until resolution.
	typedef struct packed {
		ip_t  ip;
		logic hit;
		ctr_t ctr;
	} lookup_s;

	// One entry write. Index and tag both come from ip.
	typedef struct packed {
		ip_t  ip;
		ctr_t ctr;
	} table_write_s;

endpackage
